//--- Bender.yml
package:
  name: la_decode_stage

sources:
  - logic/la_decode_pkg.sv
  - logic/stage_ifs.sv
  - logic/inst_latch.sv
  - logic/inst_decoder.sv
  - logic/regfile.sv
  - logic/operand_bypass.sv
  - logic/branch_unit.sv
  - logic/decode_stage.sv
  - target: simulation
    files:
      - verif/decode_stage_tb.sv

//--- logic/branch_unit.sv
`timescale 1ns/1ps

module branch_unit
    import la_decode_pkg::*;
(
    decode_bus_if.sink        dec,
    input  logic              ds_valid,
    input  logic              ds_to_es_valid,
    input  logic              es_allowin,
    input  logic [xlen_w-1:0] ds_pc,
    input  logic [xlen_w-1:0] rj_value,
    input  logic [xlen_w-1:0] rkd_value,
    output logic              br_redirect,
    output logic [xlen_w-1:0] br_target
);
    logic eq;
    logic lt_s;
    logic lt_u;
    logic taken;

    assign eq   = (rj_value == rkd_value);
    assign lt_u = (rj_value < rkd_value);
    assign lt_s = ($signed(rj_value) < $signed(rkd_value));

    assign taken = dec.is_b || dec.is_bl || dec.is_jirl
                || (dec.is_beq  &&  eq)   || (dec.is_bne  && !eq)
                || (dec.is_blt  &&  lt_s) || (dec.is_bge  && !lt_s)
                || (dec.is_bltu &&  lt_u) || (dec.is_bgeu && !lt_u);

    // no predictor, so every taken branch redirects once it moves on
    assign br_redirect = ds_valid && taken && ds_to_es_valid && es_allowin;
    assign br_target   = (dec.is_jirl ? rj_value : ds_pc) + dec.imm;

    a_transfer_needs_valid: assert final (ds_to_es_valid !== 1'b1 || ds_valid === 1'b1);
endmodule

//--- logic/decode_stage.sv
`timescale 1ns/1ps

module decode_stage
    import la_decode_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush,
    input  logic                  fs_valid,
    input  logic [xlen_w-1:0]     fs_pc,
    input  logic [xlen_w-1:0]     fs_inst,
    output logic                  ds_allowin,
    input  logic                  es_allowin,
    output logic                  ds_to_es_valid,
    output logic [xlen_w-1:0]     ds_pc,
    output logic [alu_op_w-1:0]   alu_op,
    output logic                  src1_is_pc,
    output logic                  src2_is_imm,
    output logic                  src2_is_4,
    output logic                  gr_we,
    output logic [reg_addr_w-1:0] dest,
    output logic [xlen_w-1:0]     imm,
    output logic                  load_op,
    output logic                  store_op,
    output mem_size_t             mem_size,
    output logic                  mem_sign,
    output logic [xlen_w-1:0]     rj_value,
    output logic [xlen_w-1:0]     rkd_value,
    output logic                  excp_ine,
    input  logic                  es_fwd_en,
    input  logic [reg_addr_w-1:0] es_fwd_reg,
    input  logic [xlen_w-1:0]     es_fwd_data,
    input  logic                  es_fwd_stall,
    input  logic                  ms_fwd_en,
    input  logic [reg_addr_w-1:0] ms_fwd_reg,
    input  logic [xlen_w-1:0]     ms_fwd_data,
    input  logic                  ms_fwd_stall,
    input  logic                  rf_we,
    input  logic [reg_addr_w-1:0] rf_waddr,
    input  logic [xlen_w-1:0]     rf_wdata,
    output logic                  br_redirect,
    output logic [xlen_w-1:0]     br_target
);
    logic              ds_valid;
    logic [xlen_w-1:0] ds_inst;
    logic              stall;

    decode_bus_if dbus ();
    rf_read_if    rbus ();

    inst_latch u_latch (.*, .redirect(br_redirect));

    inst_decoder u_decoder (.ds_inst(ds_inst), .bus(dbus));

    regfile u_regfile (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (rf_we),
        .waddr (rf_waddr),
        .wdata (rf_wdata),
        .rport (rbus)
    );

    operand_bypass u_bypass (.*, .dec(dbus), .rf(rbus));

    branch_unit u_branch (.*, .dec(dbus));

    assign alu_op      = dbus.alu_op;
    assign src1_is_pc  = dbus.src1_is_pc;
    assign src2_is_imm = dbus.src2_is_imm;
    assign src2_is_4   = dbus.src2_is_4;
    assign gr_we       = dbus.gr_we;
    assign dest        = dbus.dest;
    assign imm         = dbus.imm;
    assign load_op     = dbus.load_op;
    assign store_op    = dbus.store_op;
    assign mem_size    = dbus.mem_size;
    assign mem_sign    = dbus.mem_sign;
    assign excp_ine    = dbus.excp_ine;
endmodule

//--- logic/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder
    import la_decode_pkg::*;
(
    input  logic [xlen_w-1:0] ds_inst,
    decode_bus_if.dec         bus
);
    inst_word_u          iw;
    logic [5:0]          op6;
    logic [3:0]          op4;
    logic [1:0]          op2;
    logic [4:0]          op5;
    logic [alu_op_w-1:0] alu_op;
    logic reg3_grp, shift_grp, imm_grp, mem_grp;
    logic inst_add_w, inst_sub_w, inst_slt, inst_sltu, inst_nor, inst_and, inst_or;
    logic inst_xor, inst_orn, inst_andn, inst_sll_w, inst_srl_w, inst_sra_w;
    logic inst_slli_w, inst_srli_w, inst_srai_w, inst_addi_w, inst_slti, inst_sltui;
    logic inst_andi, inst_ori, inst_xori, inst_lu12i_w, inst_pcaddu12i;
    logic inst_ld_b, inst_ld_h, inst_ld_w, inst_ld_bu, inst_ld_hu;
    logic inst_st_b, inst_st_h, inst_st_w;
    logic is_load, is_store, is_cond_br, inst_valid;
    logic need_ui5, need_si12, need_ui12, need_si16, need_si20, need_si26;

    assign iw  = ds_inst;
    assign op6 = iw.i16.opcode;
    assign op4 = iw.i12.opcode[3:0];
    assign op2 = iw.reg3.opcode[6:5];
    assign op5 = iw.reg3.opcode[4:0];

    assign imm_grp   = (op6 == op6_alu);
    assign reg3_grp  = imm_grp && (op4 == op4_reg) && (op2 == op2_reg);
    assign shift_grp = imm_grp && (op4 == op4_shift) && (op2 == op2_shift);
    assign mem_grp   = (op6 == op6_mem);

    assign inst_add_w  = reg3_grp && (op5 == op5_add);
    assign inst_sub_w  = reg3_grp && (op5 == op5_sub);
    assign inst_slt    = reg3_grp && (op5 == op5_slt);
    assign inst_sltu   = reg3_grp && (op5 == op5_sltu);
    assign inst_nor    = reg3_grp && (op5 == op5_nor);
    assign inst_and    = reg3_grp && (op5 == op5_and);
    assign inst_or     = reg3_grp && (op5 == op5_or);
    assign inst_xor    = reg3_grp && (op5 == op5_xor);
    assign inst_orn    = reg3_grp && (op5 == op5_orn);
    assign inst_andn   = reg3_grp && (op5 == op5_andn);
    assign inst_sll_w  = reg3_grp && (op5 == op5_sll);
    assign inst_srl_w  = reg3_grp && (op5 == op5_srl);
    assign inst_sra_w  = reg3_grp && (op5 == op5_sra);
    assign inst_slli_w = shift_grp && (op5 == op5_slli);
    assign inst_srli_w = shift_grp && (op5 == op5_srli);
    assign inst_srai_w = shift_grp && (op5 == op5_srai);
    assign inst_slti   = imm_grp && (op4 == op4_slti);
    assign inst_sltui  = imm_grp && (op4 == op4_sltui);
    assign inst_addi_w = imm_grp && (op4 == op4_addi);
    assign inst_andi   = imm_grp && (op4 == op4_andi);
    assign inst_ori    = imm_grp && (op4 == op4_ori);
    assign inst_xori   = imm_grp && (op4 == op4_xori);
    assign inst_lu12i_w   = (iw.i20.opcode == op7_lu12i);
    assign inst_pcaddu12i = (iw.i20.opcode == op7_pcaddu12i);
    assign inst_ld_b  = mem_grp && (op4 == op4_ld_b);
    assign inst_ld_h  = mem_grp && (op4 == op4_ld_h);
    assign inst_ld_w  = mem_grp && (op4 == op4_ld_w);
    assign inst_ld_bu = mem_grp && (op4 == op4_ld_bu);
    assign inst_ld_hu = mem_grp && (op4 == op4_ld_hu);
    assign inst_st_b  = mem_grp && (op4 == op4_st_b);
    assign inst_st_h  = mem_grp && (op4 == op4_st_h);
    assign inst_st_w  = mem_grp && (op4 == op4_st_w);

    assign bus.is_jirl = (op6 == op6_jirl);
    assign bus.is_b    = (op6 == op6_b);
    assign bus.is_bl   = (op6 == op6_bl);
    assign bus.is_beq  = (op6 == op6_beq);
    assign bus.is_bne  = (op6 == op6_bne);
    assign bus.is_blt  = (op6 == op6_blt);
    assign bus.is_bge  = (op6 == op6_bge);
    assign bus.is_bltu = (op6 == op6_bltu);
    assign bus.is_bgeu = (op6 == op6_bgeu);

    assign is_load    = inst_ld_b | inst_ld_h | inst_ld_w | inst_ld_bu | inst_ld_hu;
    assign is_store   = inst_st_b | inst_st_h | inst_st_w;
    assign is_cond_br = bus.is_beq | bus.is_bne | bus.is_blt | bus.is_bge
                      | bus.is_bltu | bus.is_bgeu;

    always_comb begin
        alu_op = '0;
        // address and link arithmetic also go through the adder
        alu_op[alu_add]  = inst_add_w | inst_addi_w | is_load | is_store | bus.is_jirl
                         | bus.is_bl | inst_pcaddu12i;
        alu_op[alu_sub]  = inst_sub_w;
        alu_op[alu_slt]  = inst_slt | inst_slti;
        alu_op[alu_sltu] = inst_sltu | inst_sltui;
        alu_op[alu_and]  = inst_and | inst_andi;
        alu_op[alu_nor]  = inst_nor;
        alu_op[alu_or]   = inst_or | inst_ori;
        alu_op[alu_xor]  = inst_xor | inst_xori;
        alu_op[alu_sll]  = inst_sll_w | inst_slli_w;
        alu_op[alu_srl]  = inst_srl_w | inst_srli_w;
        alu_op[alu_sra]  = inst_sra_w | inst_srai_w;
        alu_op[alu_lui]  = inst_lu12i_w;
        alu_op[alu_andn] = inst_andn;
        alu_op[alu_orn]  = inst_orn;
    end
    assign bus.alu_op = alu_op;

    assign inst_valid = (|alu_op) | bus.is_b | is_cond_br;
    assign bus.excp_ine = !inst_valid;

    assign need_ui5  = inst_slli_w | inst_srli_w | inst_srai_w;
    assign need_si12 = inst_addi_w | inst_slti | inst_sltui | is_load | is_store;
    assign need_ui12 = inst_andi | inst_ori | inst_xori;
    assign need_si16 = bus.is_jirl | is_cond_br;
    assign need_si20 = inst_lu12i_w | inst_pcaddu12i;
    assign need_si26 = bus.is_b | bus.is_bl;

    assign bus.imm = ({xlen_w{need_ui5}}  & {27'b0, iw.reg3.rk})
                   | ({xlen_w{need_si12}} & {{20{iw.i12.imm[11]}}, iw.i12.imm})
                   | ({xlen_w{need_ui12}} & {20'b0, iw.i12.imm})
                   | ({xlen_w{need_si16}} & {{14{iw.i16.offs[15]}}, iw.i16.offs, 2'b0})
                   | ({xlen_w{need_si20}} & {iw.i20.imm, 12'b0})
                   | ({xlen_w{need_si26}} & {{4{iw.i26.offs_hi[9]}}, iw.i26.offs_hi,
                                             iw.i26.offs_lo, 2'b0});

    assign bus.src1_is_pc  = bus.is_jirl | bus.is_bl | inst_pcaddu12i;
    assign bus.src2_is_imm = need_ui5 | need_si12 | need_ui12 | need_si20;
    assign bus.src2_is_4   = bus.is_jirl | bus.is_bl;
    assign bus.gr_we       = inst_valid & !is_store & !is_cond_br & !bus.is_b;
    assign bus.dest        = bus.is_bl ? reg_addr_w'(1) : iw.reg3.rd;
    assign bus.load_op     = is_load;
    assign bus.store_op    = is_store;
    assign bus.mem_sign    = inst_ld_b | inst_ld_h;
    assign bus.mem_size    = (inst_ld_b | inst_ld_bu | inst_st_b) ? mem_byte :
                             (inst_ld_h | inst_ld_hu | inst_st_h) ? mem_half : mem_word;

    // branches and stores compare or store rd
    assign bus.raddr1 = iw.reg3.rj;
    assign bus.raddr2 = (is_cond_br | is_store) ? iw.reg3.rd : iw.reg3.rk;

    a_alu_onehot: assert final ($isunknown(ds_inst) || $onehot0(alu_op));
endmodule

//--- logic/inst_latch.sv
`timescale 1ns/1ps

module inst_latch
    import la_decode_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush,
    input  logic              fs_valid,
    input  logic [xlen_w-1:0] fs_pc,
    input  logic [xlen_w-1:0] fs_inst,
    input  logic              es_allowin,
    input  logic              stall,
    input  logic              redirect,
    output logic              ds_valid,
    output logic [xlen_w-1:0] ds_pc,
    output logic [xlen_w-1:0] ds_inst,
    output logic              ds_allowin,
    output logic              ds_to_es_valid
);
    logic ready_go;

    assign ready_go       = !stall;
    assign ds_allowin     = !ds_valid || (ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ready_go;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ds_valid <= 1'b0;
        end else if (flush) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            // word behind a taken branch is wrong path
            ds_valid <= fs_valid && !redirect;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_valid && ds_allowin) begin
            ds_pc   <= fs_pc;
            ds_inst <= fs_inst;
        end
    end

    // a stalled word stays in place
    a_hold_in_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        ds_valid && stall && !flush |=> ds_valid && $stable(ds_pc) && $stable(ds_inst)
    );
endmodule

//--- logic/la_decode_pkg.sv
package la_decode_pkg;

    localparam int xlen_w     = 32;
    localparam int nreg       = 32;
    localparam int reg_addr_w = 5;
    localparam int alu_op_w   = 14;

    // one-hot alu operation bits
    localparam int alu_add  = 0;
    localparam int alu_sub  = 1;
    localparam int alu_slt  = 2;
    localparam int alu_sltu = 3;
    localparam int alu_and  = 4;
    localparam int alu_nor  = 5;
    localparam int alu_or   = 6;
    localparam int alu_xor  = 7;
    localparam int alu_sll  = 8;
    localparam int alu_srl  = 9;
    localparam int alu_sra  = 10;
    localparam int alu_lui  = 11;
    localparam int alu_andn = 12;
    localparam int alu_orn  = 13;

    // inst[31:26]
    localparam logic [5:0] op6_alu  = 6'h00;
    localparam logic [5:0] op6_mem  = 6'h0a;
    localparam logic [5:0] op6_jirl = 6'h13;
    localparam logic [5:0] op6_b    = 6'h14;
    localparam logic [5:0] op6_bl   = 6'h15;
    localparam logic [5:0] op6_beq  = 6'h16;
    localparam logic [5:0] op6_bne  = 6'h17;
    localparam logic [5:0] op6_blt  = 6'h18;
    localparam logic [5:0] op6_bge  = 6'h19;
    localparam logic [5:0] op6_bltu = 6'h1a;
    localparam logic [5:0] op6_bgeu = 6'h1b;

    // inst[31:25] of the 20-bit immediate forms
    localparam logic [6:0] op7_lu12i     = 7'h0a;
    localparam logic [6:0] op7_pcaddu12i = 7'h0e;

    // inst[25:22] under op6_alu
    localparam logic [3:0] op4_reg   = 4'h0;
    localparam logic [3:0] op4_shift = 4'h1;
    localparam logic [3:0] op4_slti  = 4'h8;
    localparam logic [3:0] op4_sltui = 4'h9;
    localparam logic [3:0] op4_addi  = 4'ha;
    localparam logic [3:0] op4_andi  = 4'hd;
    localparam logic [3:0] op4_ori   = 4'he;
    localparam logic [3:0] op4_xori  = 4'hf;

    // inst[25:22] under op6_mem
    localparam logic [3:0] op4_ld_b  = 4'h0;
    localparam logic [3:0] op4_ld_h  = 4'h1;
    localparam logic [3:0] op4_ld_w  = 4'h2;
    localparam logic [3:0] op4_st_b  = 4'h4;
    localparam logic [3:0] op4_st_h  = 4'h5;
    localparam logic [3:0] op4_st_w  = 4'h6;
    localparam logic [3:0] op4_ld_bu = 4'h8;
    localparam logic [3:0] op4_ld_hu = 4'h9;

    // inst[21:20]
    localparam logic [1:0] op2_shift = 2'h0;
    localparam logic [1:0] op2_reg   = 2'h1;

    // inst[19:15]
    localparam logic [4:0] op5_add  = 5'h00;
    localparam logic [4:0] op5_sub  = 5'h02;
    localparam logic [4:0] op5_slt  = 5'h04;
    localparam logic [4:0] op5_sltu = 5'h05;
    localparam logic [4:0] op5_nor  = 5'h08;
    localparam logic [4:0] op5_and  = 5'h09;
    localparam logic [4:0] op5_or   = 5'h0a;
    localparam logic [4:0] op5_xor  = 5'h0b;
    localparam logic [4:0] op5_orn  = 5'h0c;
    localparam logic [4:0] op5_andn = 5'h0d;
    localparam logic [4:0] op5_sll  = 5'h0e;
    localparam logic [4:0] op5_srl  = 5'h0f;
    localparam logic [4:0] op5_sra  = 5'h10;
    localparam logic [4:0] op5_slli = 5'h01;
    localparam logic [4:0] op5_srli = 5'h09;
    localparam logic [4:0] op5_srai = 5'h11;

    typedef enum logic [1:0] {
        mem_word = 2'b00,
        mem_byte = 2'b01,
        mem_half = 2'b10
    } mem_size_t;

    // one instruction word, seen through each encoding format
    typedef union packed {
        struct packed {
            logic [16:0] opcode;
            logic [4:0]  rk;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } reg3;
        struct packed {
            logic [9:0]  opcode;
            logic [11:0] imm;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } i12;
        struct packed {
            logic [5:0]  opcode;
            logic [15:0] offs;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } i16;
        struct packed {
            logic [6:0]  opcode;
            logic [19:0] imm;
            logic [4:0]  rd;
        } i20;
        struct packed {
            logic [5:0]  opcode;
            logic [15:0] offs_lo;
            logic [9:0]  offs_hi;
        } i26;
    } inst_word_u;

endpackage

//--- logic/operand_bypass.sv
`timescale 1ns/1ps

module operand_bypass
    import la_decode_pkg::*;
(
    decode_bus_if.sink            dec,
    rf_read_if.reader             rf,
    input  logic                  ds_valid,
    input  logic                  es_fwd_en,
    input  logic [reg_addr_w-1:0] es_fwd_reg,
    input  logic [xlen_w-1:0]     es_fwd_data,
    input  logic                  es_fwd_stall,
    input  logic                  ms_fwd_en,
    input  logic [reg_addr_w-1:0] ms_fwd_reg,
    input  logic [xlen_w-1:0]     ms_fwd_data,
    input  logic                  ms_fwd_stall,
    output logic [xlen_w-1:0]     rj_value,
    output logic [xlen_w-1:0]     rkd_value,
    output logic                  stall
);
    logic rj_stall;
    logic rkd_stall;

    // youngest producer first, r0 never forwards
    function automatic logic [xlen_w:0] pick(input logic [reg_addr_w-1:0] ra,
                                             input logic [xlen_w-1:0]     file_data);
        if ((ra != '0) && es_fwd_en && (es_fwd_reg == ra)) begin
            return {es_fwd_stall, es_fwd_data};
        end
        if ((ra != '0) && ms_fwd_en && (ms_fwd_reg == ra)) begin
            return {ms_fwd_stall, ms_fwd_data};
        end
        return {1'b0, file_data};
    endfunction

    assign rf.raddr1 = dec.raddr1;
    assign rf.raddr2 = dec.raddr2;

    always_comb begin
        {rj_stall, rj_value}   = pick(dec.raddr1, rf.rdata1);
        {rkd_stall, rkd_value} = pick(dec.raddr2, rf.rdata2);
    end

    assign stall = ds_valid && (rj_stall || rkd_stall);
endmodule

//--- logic/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 we,
    input  logic [la_decode_pkg::reg_addr_w-1:0] waddr,
    input  logic [la_decode_pkg::xlen_w-1:0]     wdata,
    rf_read_if.file                              rport
);
    logic [la_decode_pkg::xlen_w-1:0] mem [la_decode_pkg::nreg];

    always_ff @(posedge clk) begin
        if (we && (waddr != '0)) begin
            mem[waddr] <= wdata;
        end
    end

    // r0 cell is never written
    assign rport.rdata1 = (rport.raddr1 == '0) ? '0 : mem[rport.raddr1];
    assign rport.rdata2 = (rport.raddr2 == '0) ? '0 : mem[rport.raddr2];

    a_waddr_known: assert property (
        @(posedge clk) disable iff (!rst_n) we |-> !$isunknown(waddr)
    );
endmodule

//--- logic/stage_ifs.sv
`timescale 1ns/1ps

interface decode_bus_if
    import la_decode_pkg::*;
();
    logic [alu_op_w-1:0]   alu_op;
    logic                  src1_is_pc, src2_is_imm, src2_is_4, gr_we;
    logic [reg_addr_w-1:0] dest;
    logic [xlen_w-1:0]     imm;
    logic                  load_op, store_op, mem_sign;
    mem_size_t             mem_size;
    logic [reg_addr_w-1:0] raddr1, raddr2;
    logic                  is_b, is_bl, is_jirl;
    logic                  is_beq, is_bne, is_blt, is_bge, is_bltu, is_bgeu;
    logic                  excp_ine;

    modport dec (
        output alu_op, src1_is_pc, src2_is_imm, src2_is_4, gr_we, dest, imm,
        output load_op, store_op, mem_size, mem_sign, raddr1, raddr2,
        output is_b, is_bl, is_jirl, is_beq, is_bne, is_blt, is_bge, is_bltu, is_bgeu,
        output excp_ine
    );

    modport sink (
        input alu_op, src1_is_pc, src2_is_imm, src2_is_4, gr_we, dest, imm,
        input load_op, store_op, mem_size, mem_sign, raddr1, raddr2,
        input is_b, is_bl, is_jirl, is_beq, is_bne, is_blt, is_bge, is_bltu, is_bgeu,
        input excp_ine
    );
endinterface

interface rf_read_if
    import la_decode_pkg::*;
();
    logic [reg_addr_w-1:0] raddr1, raddr2;
    logic [xlen_w-1:0]     rdata1, rdata2;

    modport reader (output raddr1, raddr2, input rdata1, rdata2);
    modport file (input raddr1, raddr2, output rdata1, rdata2);
endinterface

//--- src.f
logic/la_decode_pkg.sv
logic/stage_ifs.sv
logic/inst_latch.sv
logic/inst_decoder.sv
logic/regfile.sv
logic/operand_bypass.sv
logic/branch_unit.sv
logic/decode_stage.sv
verif/decode_stage_tb.sv

//--- verif/decode_stage_tb.sv
`timescale 1ns/1ps

module decode_stage_tb
    import la_decode_pkg::*;
();
    localparam int n_br_pairs = 8;
    // reset, then tests one to five in cycles, doubled for slack
    localparam int max_cycles = 2 * (9 + 14 + 18 + 16 + n_br_pairs * 16 + 7 + 8);

    logic                  clk, rst_n, flush;
    logic                  fs_valid;
    logic [xlen_w-1:0]     fs_pc, fs_inst;
    logic                  ds_allowin, es_allowin, ds_to_es_valid;
    logic [xlen_w-1:0]     ds_pc;
    logic [alu_op_w-1:0]   alu_op;
    logic                  src1_is_pc, src2_is_imm, src2_is_4, gr_we;
    logic [reg_addr_w-1:0] dest;
    logic [xlen_w-1:0]     imm, rj_value, rkd_value, br_target;
    logic                  load_op, store_op, mem_sign, excp_ine, br_redirect;
    mem_size_t             mem_size;
    logic                  es_fwd_en, es_fwd_stall, ms_fwd_en, ms_fwd_stall;
    logic [reg_addr_w-1:0] es_fwd_reg, ms_fwd_reg;
    logic [xlen_w-1:0]     es_fwd_data, ms_fwd_data;
    logic                  rf_we;
    logic [reg_addr_w-1:0] rf_waddr;
    logic [xlen_w-1:0]     rf_wdata;

    int     errors = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    int     cycles = 0;
    integer seed;

    decode_stage dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: tests still running after %0d cycles", cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic compare(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %0d %s: pass", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: fail, %0d errors", tests_run, name, errors - errors_before);
        end
    endtask

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        @(negedge clk);
        rf_we    = 1'b1;
        rf_waddr = addr;
        rf_wdata = data;
        @(negedge clk);
        rf_we = 1'b0;
    endtask

    // returns once the word sits in the stage
    task automatic send(input logic [31:0] pc, input logic [31:0] inst);
        @(negedge clk);
        fs_valid = 1'b1;
        fs_pc    = pc;
        fs_inst  = inst;
        #1;
        while (!ds_allowin) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        fs_valid = 1'b0;
        #1;
    endtask

    task automatic reg_alu_read();
        int          e;
        logic [31:0] v4, v5;
        e  = errors;
        v4 = $random(seed);
        v5 = $random(seed);
        compare("ds_allowin", ds_allowin, 1);
        compare("ds_to_es_valid", ds_to_es_valid, 0);
        compare("br_redirect", br_redirect, 0);
        write_reg(5'd0, $random(seed));
        write_reg(5'd4, v4);
        write_reg(5'd5, v5);
        // add.w r3, r4, r5
        send(32'h1c00_0000, {17'h00020, 5'd5, 5'd4, 5'd3});
        compare("ds_to_es_valid", ds_to_es_valid, 1);
        compare("alu_op", alu_op, 14'd1 << alu_add);
        compare("gr_we", gr_we, 1);
        compare("src1_is_pc", src1_is_pc, 0);
        compare("src2_is_4", src2_is_4, 0);
        compare("dest", dest, 3);
        compare("rj_value", rj_value, v4);
        compare("rkd_value", rkd_value, v5);
        // sub.w r6, r5, r4
        send(32'h1c00_0004, {17'h00022, 5'd4, 5'd5, 5'd6});
        compare("alu_op", alu_op, 14'd1 << alu_sub);
        compare("dest", dest, 6);
        compare("rj_value", rj_value, v5);
        compare("rkd_value", rkd_value, v4);
        // sltu r7, r0, r5
        send(32'h1c00_0008, {17'h00025, 5'd5, 5'd0, 5'd7});
        compare("alu_op", alu_op, 14'd1 << alu_sltu);
        compare("dest", dest, 7);
        compare("rj_value", rj_value, 0);
        compare("rkd_value", rkd_value, v5);
        // orn r8, r4, r0
        send(32'h1c00_000c, {17'h0002c, 5'd0, 5'd4, 5'd8});
        compare("alu_op", alu_op, 14'd1 << alu_orn);
        compare("gr_we", gr_we, 1);
        compare("rj_value", rj_value, v4);
        compare("rkd_value", rkd_value, 0);
        report("register alu", e);
    endtask

    task automatic immediate_forms();
        int          e;
        logic [31:0] v5;
        e  = errors;
        v5 = $random(seed);
        write_reg(5'd5, v5);
        // addi.w r2, r4, -5
        send(32'h1c00_0100, {10'h00a, 12'hffb, 5'd4, 5'd2});
        compare("imm", imm, 32'hffff_fffb);
        compare("src2_is_imm", src2_is_imm, 1);
        compare("alu_op", alu_op, 14'd1 << alu_add);
        compare("load_op", load_op, 0);
        compare("excp_ine", excp_ine, 0);
        // andi zero-extends
        send(32'h1c00_0104, {10'h00d, 12'h8f0, 5'd4, 5'd2});
        compare("imm", imm, 32'h0000_08f0);
        compare("alu_op", alu_op, 14'd1 << alu_and);
        // slli.w r2, r4, 13
        send(32'h1c00_0108, {17'h00081, 5'd13, 5'd4, 5'd2});
        compare("imm", imm, 13);
        compare("alu_op", alu_op, 14'd1 << alu_sll);
        compare("src2_is_imm", src2_is_imm, 1);
        send(32'h1c00_010c, {7'h0a, 20'h80123, 5'd2});
        compare("imm", imm, 32'h8012_3000);
        compare("alu_op", alu_op, 14'd1 << alu_lui);
        // ld.h r9, r4, 0x7fc
        send(32'h1c00_0110, {10'h0a1, 12'h7fc, 5'd4, 5'd9});
        compare("imm", imm, 32'h0000_07fc);
        compare("load_op", load_op, 1);
        compare("store_op", store_op, 0);
        compare("mem_size", mem_size, mem_half);
        compare("mem_sign", mem_sign, 1);
        compare("gr_we", gr_we, 1);
        compare("dest", dest, 9);
        // st.b r5, r4, -0x7ff
        send(32'h1c00_0114, {10'h0a4, 12'h801, 5'd4, 5'd5});
        compare("imm", imm, 32'hffff_f801);
        compare("store_op", store_op, 1);
        compare("load_op", load_op, 0);
        compare("mem_size", mem_size, mem_byte);
        compare("gr_we", gr_we, 0);
        compare("rkd_value", rkd_value, v5);
        send(32'h1c00_0118, 32'hffff_ffff);
        compare("excp_ine", excp_ine, 1);
        report("immediates", e);
    endtask

    task automatic bypass_and_stall();
        int          e;
        int          hold;
        logic [31:0] d_es, d_ms, d_late;
        e      = errors;
        d_es   = $random(seed);
        d_ms   = $random(seed);
        d_late = $random(seed);
        hold   = 2 + ($unsigned($random(seed)) % 4);
        @(negedge clk);
        es_fwd_en   = 1'b1;
        es_fwd_reg  = 5'd4;
        es_fwd_data = d_es;
        ms_fwd_en   = 1'b1;
        ms_fwd_reg  = 5'd4;
        ms_fwd_data = d_ms;
        send(32'h1c00_0200, {17'h00020, 5'd5, 5'd4, 5'd3});
        compare("rj_value", rj_value, d_es);
        @(negedge clk);
        es_fwd_en = 1'b0;
        send(32'h1c00_0204, {17'h00020, 5'd5, 5'd4, 5'd3});
        compare("rj_value", rj_value, d_ms);
        @(negedge clk);
        ms_fwd_en    = 1'b0;
        es_fwd_en    = 1'b1;
        es_fwd_stall = 1'b1;
        es_fwd_data  = d_late;
        // add.w r3, r0, r4 so the producer feeds rk
        send(32'h1c00_0208, {17'h00020, 5'd4, 5'd0, 5'd3});
        repeat (hold) begin
            compare("ds_to_es_valid", ds_to_es_valid, 0);
            compare("ds_allowin", ds_allowin, 0);
            @(negedge clk);
        end
        es_fwd_stall = 1'b0;
        #1;
        compare("ds_to_es_valid", ds_to_es_valid, 1);
        compare("rkd_value", rkd_value, d_late);
        @(negedge clk);
        es_fwd_en = 1'b0;
        report("bypass and stall", e);
    endtask

    task automatic branch_resolve();
        int          e;
        int          off_bytes;
        logic [31:0] a, b, pc;
        logic [15:0] offs;
        logic [5:0]  op;
        logic        taken;
        e = errors;
        for (int i = 0; i < n_br_pairs; i++) begin
            a = $random(seed);
            b = (i % 3 == 0) ? a : $random(seed);
            write_reg(5'd4, a);
            write_reg(5'd5, b);
            // beq, bne, blt, bge, bltu, bgeu in opcode order
            for (int k = 0; k < 6; k++) begin
                op   = 6'h16 + 6'(k);
                offs = $random(seed);
                pc   = 32'h1c00_1000 + i * 64 + k * 4;
                // word offset in bytes
                off_bytes = 4 * $signed(offs);
                case (k)
                    0: taken = (a == b);
                    1: taken = (a != b);
                    2: taken = ($signed(a) < $signed(b));
                    3: taken = ($signed(a) >= $signed(b));
                    4: taken = (a < b);
                    default: taken = (a >= b);
                endcase
                send(pc, {op, offs, 5'd4, 5'd5});
                compare("br_redirect", br_redirect, taken);
                compare("br_target", br_target, pc + off_bytes);
            end
        end
        // jirl r0, r4, 8
        send(32'h1c00_2000, {6'h13, 16'h0002, 5'd4, 5'd0});
        compare("br_redirect", br_redirect, 1);
        compare("br_target", br_target, a + 32'h8);
        compare("src1_is_pc", src1_is_pc, 1);
        compare("src2_is_4", src2_is_4, 1);
        // bl back by 64 bytes
        send(32'h1c00_2100, {6'h15, 16'hfff0, 10'h3ff});
        compare("dest", dest, 1);
        compare("gr_we", gr_we, 1);
        compare("src1_is_pc", src1_is_pc, 1);
        compare("src2_is_4", src2_is_4, 1);
        compare("br_redirect", br_redirect, 1);
        compare("br_target", br_target, 32'h1c00_20c0);
        @(negedge clk);
        fs_valid = 1'b1;
        fs_pc    = 32'h1c00_2200;
        fs_inst  = {6'h16, 16'h0004, 5'd4, 5'd4};
        @(negedge clk);
        // wrong-path word next to the taken beq
        fs_pc   = 32'h1c00_2204;
        fs_inst = {17'h00020, 5'd5, 5'd4, 5'd3};
        #1;
        compare("br_redirect", br_redirect, 1);
        @(negedge clk);
        fs_valid = 1'b0;
        #1;
        compare("ds_to_es_valid", ds_to_es_valid, 0);
        report("branches", e);
    endtask

    task automatic backpressure_flush();
        int e;
        e = errors;
        @(negedge clk);
        es_allowin = 1'b0;
        fs_valid   = 1'b1;
        fs_pc      = 32'h1c00_3000;
        fs_inst    = {17'h00020, 5'd5, 5'd4, 5'd3};
        @(negedge clk);
        fs_pc   = 32'h1c00_3004;
        fs_inst = {17'h00022, 5'd4, 5'd5, 5'd6};
        repeat (3) begin
            #1;
            compare("ds_allowin", ds_allowin, 0);
            compare("ds_to_es_valid", ds_to_es_valid, 1);
            compare("ds_pc", ds_pc, 32'h1c00_3000);
            compare("dest", dest, 3);
            compare("alu_op", alu_op, 14'd1 << alu_add);
            @(negedge clk);
        end
        es_allowin = 1'b1;
        @(negedge clk);
        fs_valid   = 1'b0;
        es_allowin = 1'b0;
        #1;
        compare("ds_pc", ds_pc, 32'h1c00_3004);
        compare("dest", dest, 6);
        compare("alu_op", alu_op, 14'd1 << alu_sub);
        compare("ds_to_es_valid", ds_to_es_valid, 1);
        @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush      = 1'b0;
        es_allowin = 1'b1;
        #1;
        compare("ds_to_es_valid", ds_to_es_valid, 0);
        compare("ds_allowin", ds_allowin, 1);
        report("back-pressure and flush", e);
    endtask

    initial begin
        seed         = 56;
        rst_n        = 1'b0;
        flush        = 1'b0;
        fs_valid     = 1'b0;
        fs_pc        = '0;
        fs_inst      = '0;
        es_allowin   = 1'b1;
        es_fwd_en    = 1'b0;
        es_fwd_reg   = '0;
        es_fwd_data  = '0;
        es_fwd_stall = 1'b0;
        ms_fwd_en    = 1'b0;
        ms_fwd_reg   = '0;
        ms_fwd_data  = '0;
        ms_fwd_stall = 1'b0;
        rf_we        = 1'b0;
        rf_waddr     = '0;
        rf_wdata     = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        reg_alu_read();
        immediate_forms();
        bypass_and_stall();
        branch_resolve();
        backpressure_flush();
        @(negedge clk);
        $display("summary: %0d tests, %0d failed, %0d check errors",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end
endmodule
